// ==== source/cluster_route_pkg.sv ====
package cluster_route_pkg;

    localparam int word_width = 16;
    localparam int mem_words  = 1024;

    // byte base addresses, word n of a region sits at base + 2n
    localparam logic [word_width-1:0] sinks_base       = 16'h008;
    localparam logic [word_width-1:0] neighbor_id_base = 16'h048;
    localparam logic [word_width-1:0] cluster_id_base  = 16'h0C8;
    localparam logic [word_width-1:0] battery_base     = 16'h148;
    localparam logic [word_width-1:0] qvalue_base      = 16'h1C8;
    localparam logic [word_width-1:0] hcm_base         = 16'h648;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [word_width-1:0] adr;
        logic [word_width-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                  ack;
        logic [word_width-1:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic [word_width-1:0] better_neighbors;
        logic [word_width-1:0] best_hop;
        logic [word_width-1:0] best_value;       // Q8.8
        logic [word_width-1:0] best_neighbor_id;
        logic [word_width-1:0] next_sink;
    } scan_result_t;

    typedef enum logic [2:0] {
        check_cluster,
        check_battery,
        check_qvalue,
        weigh_hop,
        read_neighbor_id,
        match_sinks,
        read_best_id,
        finished
    } scan_state_t;

    // Q8.8 times Q8.8, back to Q8.8 with saturation
    function automatic logic [word_width-1:0] q88_mul(input logic [word_width-1:0] a,
                                                      input logic [word_width-1:0] b);
        logic [31:0] prod;
        prod = (32'(a) * 32'(b)) >> 8;
        return (prod > 32'h0000_FFFF) ? 16'hFFFF : prod[15:0];
    endfunction

    // ceil((length - 1) * battery), battery in Q8.8, clamped to the last entry
    function automatic logic [word_width-1:0] hcm_index(input logic [word_width-1:0] battery,
                                                        input logic [word_width-1:0] length);
        logic [31:0] scaled;
        logic [31:0] idx;
        scaled = 32'(length - 16'd1) * 32'(battery);
        idx = (scaled + 32'd255) >> 8;
        if (idx > 32'(length - 16'd1)) begin
            idx = 32'(length - 16'd1);
        end
        return idx[15:0];
    endfunction

endpackage

// ==== source/neighbor_table_ram.sv ====
`timescale 1ns/1ps

module neighbor_table_ram
    import cluster_route_pkg::*;
(
    input  logic    clock,
    input  logic    nrst,
    input  wb_req_t bus_req,
    output wb_rsp_t bus_rsp
);

    localparam int adr_bits = $clog2(mem_words);

    logic [word_width-1:0] mem [mem_words];
    logic [word_width-1:0] rd_data;
    logic [adr_bits-1:0]   word_adr;
    logic                  ack;
    logic                  access;

    assign word_adr = bus_req.adr[adr_bits:1];  // byte address to word index
    assign access   = bus_req.cyc && bus_req.stb && !ack;

    // one access per two cycles, ack low after every ack
    always_ff @(posedge clock) begin
        if (!nrst) begin
            ack <= 1'b0;
        end else begin
            ack <= access;
        end
    end

    always_ff @(posedge clock) begin
        if (access) begin
            if (bus_req.we) begin
                mem[word_adr] <= bus_req.dat_w;  // lands with the ack edge
            end
            rd_data <= mem[word_adr];
        end
    end

    assign bus_rsp = '{ack: ack, dat_r: rd_data};

    // word aligned and inside the array
    a_adr_legal: assert property (
        @(posedge clock) disable iff (!nrst)
        bus_req.stb |-> !bus_req.adr[0] && ((32'(bus_req.adr) >> 1) < mem_words)
    ) else $error("table access to bad address %h", bus_req.adr);

endmodule

// ==== source/wb_two_master_arbiter.sv ====
`timescale 1ns/1ps

module wb_two_master_arbiter
    import cluster_route_pkg::*;
(
    input  logic    clock,
    input  logic    nrst,
    input  wb_req_t host_req,
    output wb_rsp_t host_rsp,
    input  wb_req_t scan_req,
    output wb_rsp_t scan_rsp,
    output wb_req_t mem_req,
    input  wb_rsp_t mem_rsp
);

    logic locked;      // some master owns the bus
    logic owner_scan;  // owner while locked
    logic grant_scan;

    // host wins when the bus is free
    always_comb begin
        if (locked) begin
            grant_scan = owner_scan;
        end else begin
            grant_scan = !host_req.cyc && scan_req.cyc;
        end
    end

    // hold the grant for as long as the owner keeps cyc up
    always_ff @(posedge clock) begin
        if (!nrst) begin
            locked     <= 1'b0;
            owner_scan <= 1'b0;
        end else begin
            locked     <= grant_scan ? scan_req.cyc : host_req.cyc;
            owner_scan <= grant_scan;
        end
    end

    assign mem_req = grant_scan ? scan_req : host_req;

    assign host_rsp = '{ack: mem_rsp.ack && !grant_scan, dat_r: mem_rsp.dat_r};
    assign scan_rsp = '{ack: mem_rsp.ack && grant_scan, dat_r: mem_rsp.dat_r};

    // an ack only ever answers the master granted at the access edge
    a_host_ack: assert property (
        @(posedge clock) disable iff (!nrst)
        host_rsp.ack |-> host_req.cyc && !$past(grant_scan)
    ) else $error("host saw an ack it does not own");

    a_scan_ack: assert property (
        @(posedge clock) disable iff (!nrst)
        scan_rsp.ack |-> scan_req.cyc && $past(grant_scan)
    ) else $error("scanner saw an ack it does not own");

endmodule

// ==== source/better_neighbor_scan.sv ====
`timescale 1ns/1ps

module better_neighbor_scan
    import cluster_route_pkg::*;
#(
    parameter int num_neighbors = 64,
    parameter int num_sinks     = 16,
    parameter int hcm_length    = 11
) (
    input  logic                  clock,
    input  logic                  nrst,
    input  logic                  start,
    input  logic [word_width-1:0] my_cluster_id,
    input  logic [word_width-1:0] my_best,            // Q8.8
    input  logic [word_width-1:0] battery_threshold,  // Q8.8
    output wb_req_t               bus_req,
    input  wb_rsp_t               bus_rsp,
    output logic                  done,
    output scan_result_t          result
);

    localparam logic [word_width-1:0] no_hop        = 16'(num_neighbors + 1);
    localparam logic [word_width-1:0] last_neighbor = 16'(num_neighbors - 1);
    localparam logic [word_width-1:0] last_sink     = 16'(num_sinks - 1);

    localparam scan_result_t result_init = '{
        better_neighbors: 16'd0,
        best_hop:         no_hop,
        best_value:       16'hFFFE,
        best_neighbor_id: 16'hFFFF,
        next_sink:        no_hop
    };

    scan_state_t           state;
    logic                  running;
    logic                  got_ack;
    logic [word_width-1:0] i;            // neighbor index
    logic [word_width-1:0] j;            // sink index
    logic [word_width-1:0] battery;
    logic [word_width-1:0] qvalue;
    logic [word_width-1:0] neighbor_id;
    logic [word_width-1:0] hcm_k;
    logic [word_width-1:0] weighted;
    logic [word_width-1:0] next_adr;

    assign got_ack  = bus_req.cyc && bus_rsp.ack;
    assign hcm_k    = hcm_index(battery, 16'(hcm_length));
    assign weighted = q88_mul(qvalue, bus_rsp.dat_r);

    // where the current state reads from
    always_comb begin
        case (state)
            check_cluster:    next_adr = cluster_id_base + (i << 1);
            check_battery:    next_adr = battery_base + (i << 1);
            check_qvalue:     next_adr = qvalue_base + (i << 1);
            weigh_hop:        next_adr = hcm_base + (hcm_k << 1);
            read_neighbor_id: next_adr = neighbor_id_base + (i << 1);
            match_sinks:      next_adr = sinks_base + (j << 1);
            read_best_id:     next_adr = neighbor_id_base + (result.best_hop << 1);
            default:          next_adr = '0;
        endcase
    end

    // state after neighbor idx is done with
    function automatic scan_state_t after_neighbor(input logic [word_width-1:0] idx,
                                                   input logic [word_width-1:0] hop);
        if (idx == last_neighbor) begin
            return (hop != no_hop) ? read_best_id : finished;
        end
        return check_cluster;
    endfunction

    always_ff @(posedge clock) begin
        if (!nrst) begin
            state   <= finished;
            running <= 1'b0;
            done    <= 1'b0;
            i       <= '0;
            j       <= '0;
            bus_req <= '0;
            result  <= result_init;
        end else if (start && !running) begin
            state   <= check_cluster;
            running <= 1'b1;
            done    <= 1'b0;
            i       <= '0;
            j       <= '0;
            result  <= result_init;
        end else if (running) begin
            if (state == finished) begin
                running <= 1'b0;
                done    <= 1'b1;
            end else if (!bus_req.cyc) begin
                bus_req.cyc <= 1'b1;  // open a read cycle
                bus_req.stb <= 1'b1;
                bus_req.adr <= next_adr;
            end else if (bus_rsp.ack) begin
                bus_req.cyc <= 1'b0;  // idle a cycle between reads
                bus_req.stb <= 1'b0;
                case (state)
                    check_cluster: begin
                        if (bus_rsp.dat_r != my_cluster_id) begin
                            i     <= i + 16'd1;
                            state <= after_neighbor(i, result.best_hop);
                        end else begin
                            state <= check_battery;
                        end
                    end
                    check_battery: begin
                        if (bus_rsp.dat_r < battery_threshold) begin
                            i     <= i + 16'd1;  // dead neighbor
                            state <= after_neighbor(i, result.best_hop);
                        end else begin
                            state <= check_qvalue;
                        end
                    end
                    check_qvalue: begin
                        if (bus_rsp.dat_r <= my_best) begin
                            result.better_neighbors <= result.better_neighbors + 16'd1;
                            state <= weigh_hop;
                        end else begin
                            state <= read_neighbor_id;
                        end
                    end
                    weigh_hop: begin
                        if (weighted < result.best_value) begin  // strictly lower only
                            result.best_value <= weighted;
                            result.best_hop   <= i;
                        end
                        state <= read_neighbor_id;
                    end
                    read_neighbor_id: begin
                        j     <= '0;
                        state <= match_sinks;
                    end
                    match_sinks: begin
                        if (bus_rsp.dat_r == neighbor_id) begin
                            result.next_sink <= i;  // last match wins
                        end
                        if (j == last_sink) begin
                            j     <= '0;
                            i     <= i + 16'd1;
                            state <= after_neighbor(i, result.best_hop);
                        end else begin
                            j <= j + 16'd1;
                        end
                    end
                    read_best_id: begin
                        result.best_neighbor_id <= bus_rsp.dat_r;
                        state <= finished;
                    end
                    default: state <= finished;
                endcase
            end
        end
    end

    // words kept from earlier reads of the same neighbor
    always_ff @(posedge clock) begin
        if (got_ack) begin
            case (state)
                check_battery:    battery     <= bus_rsp.dat_r;
                check_qvalue:     qvalue      <= bus_rsp.dat_r;
                read_neighbor_id: neighbor_id <= bus_rsp.dat_r;
                default:          ;
            endcase
        end
    end

    a_hcm_inside: assert property (
        @(posedge clock) disable iff (!nrst)
        bus_req.cyc && state == weigh_hop |->
            bus_req.adr >= hcm_base && bus_req.adr < hcm_base + 16'(2 * hcm_length)
    ) else $error("hop cost read outside table at %h", bus_req.adr);

    a_done_idle: assert property (
        @(posedge clock) disable iff (!nrst)
        !(done && bus_req.cyc)
    ) else $error("bus cycle open after done");

endmodule

// ==== source/cluster_route_top.sv ====
`timescale 1ns/1ps

module cluster_route_top
    import cluster_route_pkg::*;
#(
    parameter int num_neighbors = 64,
    parameter int num_sinks     = 16,
    parameter int hcm_length    = 11
) (
    input  logic                  clock,
    input  logic                  nrst,
    input  wb_req_t               host_req,
    output wb_rsp_t               host_rsp,
    input  logic                  start,
    input  logic [word_width-1:0] my_cluster_id,
    input  logic [word_width-1:0] my_best,
    input  logic [word_width-1:0] battery_threshold,
    output logic                  done,
    output scan_result_t          result
);

    wb_req_t scan_req;
    wb_rsp_t scan_rsp;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    better_neighbor_scan #(
        .num_neighbors (num_neighbors),
        .num_sinks     (num_sinks),
        .hcm_length    (hcm_length)
    ) scanner (
        .clock             (clock),
        .nrst              (nrst),
        .start             (start),
        .my_cluster_id     (my_cluster_id),
        .my_best           (my_best),
        .battery_threshold (battery_threshold),
        .bus_req           (scan_req),
        .bus_rsp           (scan_rsp),
        .done              (done),
        .result            (result)
    );

    // host has priority over the scanner
    wb_two_master_arbiter arbiter (
        .clock    (clock),
        .nrst     (nrst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .scan_req (scan_req),
        .scan_rsp (scan_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    neighbor_table_ram neighbor_table (
        .clock   (clock),
        .nrst    (nrst),
        .bus_req (mem_req),
        .bus_rsp (mem_rsp)
    );

endmodule

// ==== dv/cluster_route_tb.sv ====
`timescale 1ns/1ps

module cluster_route_tb
    import cluster_route_pkg::*;
;

    localparam int n_nb         = 64;
    localparam int n_sk         = 16;
    localparam int hcm_len      = 11;
    localparam int bus_timeout  = 50;     // cycles per host access
    localparam int scan_timeout = 20000;  // cycles per scan
    localparam logic [15:0] no_hop = 16'(n_nb + 1);

    logic         clock;
    logic         nrst;
    wb_req_t      host_req;
    wb_rsp_t      host_rsp;
    logic         start;
    logic [15:0]  my_cluster_id;
    logic [15:0]  my_best;
    logic [15:0]  battery_threshold;
    logic         done;
    scan_result_t result;

    integer seed = 38802;
    int errors = 0;
    int passed = 0;
    int failed = 0;

    // testbench copy of the neighbor table
    logic [15:0] sink_tab [n_sk];
    logic [15:0] nid_tab [n_nb];
    logic [15:0] cid_tab [n_nb];
    logic [15:0] bat_tab [n_nb];
    logic [15:0] qv_tab [n_nb];
    logic [15:0] hcm_tab [hcm_len];

    cluster_route_top dut (
        .clock             (clock),
        .nrst              (nrst),
        .host_req          (host_req),
        .host_rsp          (host_rsp),
        .start             (start),
        .my_cluster_id     (my_cluster_id),
        .my_best           (my_best),
        .battery_threshold (battery_threshold),
        .done              (done),
        .result            (result)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    function automatic logic [15:0] rand_word();
        return 16'($random(seed));
    endfunction

    // Q8.8 product, saturated
    function automatic logic [15:0] fixed_mul(input logic [15:0] a, input logic [15:0] b);
        logic [31:0] p;
        p = ({16'h0, a} * {16'h0, b}) >> 8;
        return (p > 32'h0000_FFFF) ? 16'hFFFF : p[15:0];
    endfunction

    // hop cost slot for a battery level, rounded up
    function automatic int cost_slot(input logic [15:0] bat);
        int s;
        s = ((hcm_len - 1) * int'(bat) + 255) / 256;
        return (s > hcm_len - 1) ? hcm_len - 1 : s;
    endfunction

    function automatic logic [15:0] region_base(input int r);
        case (r)
            0:       return sinks_base;
            1:       return neighbor_id_base;
            2:       return cluster_id_base;
            3:       return battery_base;
            4:       return qvalue_base;
            default: return hcm_base;
        endcase
    endfunction

    function automatic int region_len(input int r);
        case (r)
            0:       return n_sk;
            5:       return hcm_len;
            default: return n_nb;
        endcase
    endfunction

    function automatic logic [15:0] table_word(input int r, input int idx);
        case (r)
            0:       return sink_tab[idx];
            1:       return nid_tab[idx];
            2:       return cid_tab[idx];
            3:       return bat_tab[idx];
            4:       return qv_tab[idx];
            default: return hcm_tab[idx];
        endcase
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        assert (got == exp) else begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_result(input scan_result_t exp);
        check_word("result.better_neighbors", result.better_neighbors, exp.better_neighbors);
        check_word("result.best_hop", result.best_hop, exp.best_hop);
        check_word("result.best_value", result.best_value, exp.best_value);
        check_word("result.best_neighbor_id", result.best_neighbor_id, exp.best_neighbor_id);
        check_word("result.next_sink", result.next_sink, exp.next_sink);
    endtask

    // one host cycle, held until ack
    task automatic bus_cycle(input logic we, input logic [15:0] adr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        int n;
        bit got;
        n = 0;
        got = 0;
        rdata = '0;
        @(negedge clock);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
        while (!got && n < bus_timeout) begin
            @(negedge clock);
            n++;
            if (host_rsp.ack) begin
                got = 1;
                rdata = host_rsp.dat_r;
            end
        end
        @(negedge clock);  // cycle stays open through the ack edge
        host_req = '0;
        if (!got) begin
            $display("host access to %h got no ack within %0d cycles", adr, bus_timeout);
            errors++;
        end
    endtask

    task automatic host_write(input logic [15:0] adr, input logic [15:0] data);
        logic [15:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic host_read(input logic [15:0] adr, output logic [15:0] data);
        bus_cycle(1'b0, adr, 16'h0, data);
    endtask

    // random contents, cluster IDs drawn from 0 .. clusters-1
    task automatic fill_table(input int clusters);
        for (int i = 0; i < n_nb; i++) begin
            nid_tab[i] = rand_word();
            cid_tab[i] = 16'(rand_below(clusters));
            bat_tab[i] = rand_word() & 16'h01FF;
            qv_tab[i]  = rand_word() & 16'h03FF;
        end
        for (int j = 0; j < n_sk; j++) begin
            sink_tab[j] = rand_word();
        end
        for (int k = 0; k < hcm_len; k++) begin
            hcm_tab[k] = 16'h0080 + (rand_word() & 16'h03FF);
        end
    endtask

    task automatic load_table();
        for (int r = 0; r < 6; r++) begin
            for (int idx = 0; idx < region_len(r); idx++) begin
                host_write(region_base(r) + 16'(2 * idx), table_word(r, idx));
            end
        end
    endtask

    task automatic model_scan(output scan_result_t exp);
        logic [15:0] w;
        exp = '{better_neighbors: 16'h0, best_hop: no_hop, best_value: 16'hFFFE,
                best_neighbor_id: 16'hFFFF, next_sink: no_hop};
        for (int i = 0; i < n_nb; i++) begin
            if (cid_tab[i] == my_cluster_id && bat_tab[i] >= battery_threshold) begin
                if (qv_tab[i] <= my_best) begin
                    exp.better_neighbors = exp.better_neighbors + 16'd1;
                    w = fixed_mul(qv_tab[i], hcm_tab[cost_slot(bat_tab[i])]);
                    if (w < exp.best_value) begin
                        exp.best_value = w;
                        exp.best_hop   = 16'(i);
                    end
                end
                for (int j = 0; j < n_sk; j++) begin
                    if (sink_tab[j] == nid_tab[i]) begin
                        exp.next_sink = 16'(i);  // later neighbor overrides
                    end
                end
            end
        end
        if (exp.best_hop != no_hop) begin
            exp.best_neighbor_id = nid_tab[exp.best_hop];
        end
    endtask

    task automatic pulse_start();
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        @(negedge clock);
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < scan_timeout) begin
            @(negedge clock);
            n++;
        end
        if (!done) begin
            $display("scan did not finish within %0d cycles", scan_timeout);
            errors++;
        end
    endtask

    task automatic scan_and_compare();
        scan_result_t exp;
        pulse_start();
        wait_done();
        model_scan(exp);
        check_result(exp);
    endtask

    task automatic test_reset_values();
        check_word("done", 16'(done), 16'h0);
        check_result('{better_neighbors: 16'h0, best_hop: no_hop, best_value: 16'hFFFE,
                       best_neighbor_id: 16'hFFFF, next_sink: no_hop});
    endtask

    task automatic test_host_rw();
        int r;
        int idx;
        logic [15:0] adr;
        logic [15:0] wdata;
        logic [15:0] rdata;
        for (int k = 0; k < 24; k++) begin
            r     = rand_below(6);
            idx   = rand_below(region_len(r));
            adr   = region_base(r) + 16'(2 * idx);
            wdata = rand_word();
            host_write(adr, wdata);
            host_read(adr, rdata);
            check_word("host_rsp.dat_r", rdata, wdata);
        end
    endtask

    task automatic test_no_cluster();
        fill_table(4);
        for (int i = 0; i < n_nb; i++) begin
            cid_tab[i] = cid_tab[i] + 16'd1;  // never cluster 0
        end
        load_table();
        my_cluster_id = 16'h0;
        my_best = 16'h0300;
        battery_threshold = 16'h0040;
        pulse_start();
        wait_done();
        check_word("done", 16'(done), 16'h1);
        check_result('{better_neighbors: 16'h0, best_hop: no_hop, best_value: 16'hFFFE,
                       best_neighbor_id: 16'hFFFF, next_sink: no_hop});
    endtask

    task automatic test_battery_cut();
        fill_table(2);
        my_cluster_id = 16'h0;
        my_best = 16'h0200;
        battery_threshold = 16'h00C0;
        cid_tab[2] = 16'h0;
        cid_tab[3] = 16'h0;
        bat_tab[2] = 16'h00BF;  // just below threshold
        bat_tab[3] = 16'h00C0;
        qv_tab[2]  = 16'h0100;  // would be counted if let through
        qv_tab[3]  = 16'h0100;
        load_table();
        scan_and_compare();
    endtask

    task automatic test_random_sinks();
        fill_table(3);
        for (int j = 0; j < n_sk; j += 2) begin
            sink_tab[j] = nid_tab[rand_below(n_nb)];
        end
        load_table();
        my_cluster_id = 16'h1;
        my_best = 16'h0300;
        battery_threshold = 16'h0040;
        scan_and_compare();
    endtask

    task automatic test_reads_during_scan();
        scan_result_t exp;
        int r;
        int idx;
        logic [15:0] rdata;
        fill_table(2);
        for (int j = 1; j < n_sk; j += 3) begin
            sink_tab[j] = nid_tab[rand_below(n_nb)];
        end
        load_table();
        my_cluster_id = 16'h0;
        my_best = 16'h0280;
        battery_threshold = 16'h0060;
        pulse_start();
        for (int k = 0; k < 30; k++) begin
            r   = rand_below(6);
            idx = rand_below(region_len(r));
            host_read(region_base(r) + 16'(2 * idx), rdata);
            check_word("host_rsp.dat_r", rdata, table_word(r, idx));
        end
        wait_done();
        model_scan(exp);
        check_result(exp);
    endtask

    task automatic report(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: pass", name);
            passed++;
        end else begin
            $display("test %s: fail with %0d errors", name, errors - errors_before);
            failed++;
        end
    endtask

    initial begin
        int e;
        nrst = 1'b0;
        host_req = '0;
        start = 1'b0;
        my_cluster_id = 16'h0;
        my_best = 16'h0;
        battery_threshold = 16'h0;
        repeat (3) @(negedge clock);
        nrst = 1'b1;

        e = errors;
        test_reset_values();
        report("reset_values", e);
        e = errors;
        test_host_rw();
        report("host_rw", e);
        e = errors;
        test_no_cluster();
        report("no_cluster", e);
        e = errors;
        test_battery_cut();
        report("battery_cut", e);
        e = errors;
        test_random_sinks();
        report("random_sinks", e);
        e = errors;
        test_reads_during_scan();
        report("reads_during_scan", e);

        $display("%0d tests passed, %0d tests failed, %0d errors", passed, failed, errors);
        if (failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cluster_route.f ====
source/cluster_route_pkg.sv
source/neighbor_table_ram.sv
source/wb_two_master_arbiter.sv
source/better_neighbor_scan.sv
source/cluster_route_top.sv
dv/cluster_route_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cluster routing testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f cluster_route.f \
    --top-module cluster_route_tb -o cluster_route_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cluster_route_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
